// File: hdl/isaPkg.sv
package isaPkg;

    // ========================================
    // datapath widths
    // ========================================
    localparam int XLEN      = 32;               // data and address width
    localparam int REG_IDX_W = 5;                // 32 architectural registers

    // ========================================
    // opcodes of the supported subset
    // ========================================
    localparam logic [6:0] OP_RTYPE  = 7'd51;    // add, sll, xor, srl, and
    localparam logic [6:0] OP_ITYPE  = 7'd19;    // addi
    localparam logic [6:0] OP_BRANCH = 7'd99;    // beq, bne
    localparam logic [6:0] OP_JALR   = 7'd103;
    localparam logic [6:0] OP_JAL    = 7'd111;
    localparam logic [6:0] OP_LOAD   = 7'd3;     // lw, lb
    localparam logic [6:0] OP_STORE  = 7'd35;    // sw, sb

    // funct3 values of the alu group
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch and memory width groups
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BYTE = 3'b000;
    localparam logic [2:0] F3_WORD = 3'b010;

endpackage

// File: hdl/ctrlPkg.sv
package ctrlPkg;

    // codes line up with funct3 of the R-type group
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SLL = 3'b001,
        ALU_XOR = 3'b100,
        ALU_SRL = 3'b101,
        ALU_AND = 3'b111
    } aluOp_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,     // alu result
        RES_MEM = 2'd1,     // load data
        RES_PC4 = 2'd2      // link address
    } resultSrc_e;

    typedef enum logic [1:0] {
        PC_PLUS4 = 2'd0,    // sequential
        PC_REL   = 2'd1,    // pc + imm
        PC_REG   = 2'd2     // alu result with bit 0 cleared
    } pcSrc_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_B = 2'd2,
        IMM_J = 2'd3
    } immSrc_e;

    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,
        MEM_WORD = 2'd1,
        MEM_BYTE = 2'd2
    } memMode_e;

    // ========================================
    // control bundle out of the decoder
    // ========================================
    typedef struct packed {
        pcSrc_e     pcSrc;
        resultSrc_e resultSrc;
        memMode_e   memRead;
        memMode_e   memWrite;
        aluOp_e     aluOp;
        logic       aluSrc;     // set when imm is operand b
        immSrc_e    immSrc;
        logic       regWrite;
    } ctrl_t;

endpackage

// File: hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import isaPkg::*; import ctrlPkg::*; (
    input  logic [6:0] op,
    input  logic [2:0] funct3,
    input  logic       funct7,      // instr[30] selects sub and sra
    input  logic       aluZero,
    output ctrl_t      ctrl
);

    always_comb begin
        // do nothing unless a case below claims the encoding
        ctrl = '{pcSrc: PC_PLUS4, resultSrc: RES_ALU, memRead: MEM_NONE,
                 memWrite: MEM_NONE, aluOp: ALU_ADD, aluSrc: 1'b0,
                 immSrc: IMM_I, regWrite: 1'b0};

        case (op)
            // ========================================
            // arithmetic
            // ========================================
            OP_RTYPE: begin
                if (!funct7) begin      // sub and sra not supported
                    case (funct3)
                        F3_ADD: begin
                            ctrl.aluOp    = ALU_ADD;
                            ctrl.regWrite = 1'b1;
                        end
                        F3_SLL: begin
                            ctrl.aluOp    = ALU_SLL;
                            ctrl.regWrite = 1'b1;
                        end
                        F3_XOR: begin
                            ctrl.aluOp    = ALU_XOR;
                            ctrl.regWrite = 1'b1;
                        end
                        F3_SRL: begin
                            ctrl.aluOp    = ALU_SRL;
                            ctrl.regWrite = 1'b1;
                        end
                        F3_AND: begin
                            ctrl.aluOp    = ALU_AND;
                            ctrl.regWrite = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end

            OP_ITYPE: begin
                case (funct3)
                    F3_ADD: begin               // addi
                        ctrl.aluSrc   = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end
                    default: ;
                endcase
            end

            // ========================================
            // control flow
            // ========================================
            OP_BRANCH: begin
                case (funct3)
                    F3_BEQ: begin
                        ctrl.aluOp  = ALU_XOR;  // zero means equal
                        ctrl.immSrc = IMM_B;
                        ctrl.pcSrc  = aluZero ? PC_REL : PC_PLUS4;
                    end
                    F3_BNE: begin
                        ctrl.aluOp  = ALU_XOR;
                        ctrl.immSrc = IMM_B;
                        ctrl.pcSrc  = aluZero ? PC_PLUS4 : PC_REL;
                    end
                    default: ;
                endcase
            end

            OP_JALR: begin
                case (funct3)
                    F3_ADD: begin
                        ctrl.pcSrc     = PC_REG;    // rs1 + imm
                        ctrl.resultSrc = RES_PC4;   // link
                        ctrl.aluSrc    = 1'b1;
                        ctrl.regWrite  = 1'b1;
                    end
                    default: ;
                endcase
            end

            OP_JAL: begin
                ctrl.pcSrc     = PC_REL;            // alu unused
                ctrl.resultSrc = RES_PC4;
                ctrl.immSrc    = IMM_J;
                ctrl.regWrite  = 1'b1;
            end

            // ========================================
            // memory
            // ========================================
            OP_LOAD: begin
                case (funct3)
                    F3_WORD, F3_BYTE: begin
                        ctrl.memRead   = (funct3 == F3_WORD) ? MEM_WORD : MEM_BYTE;
                        ctrl.resultSrc = RES_MEM;
                        ctrl.aluSrc    = 1'b1;      // base + offset
                        ctrl.regWrite  = 1'b1;
                    end
                    default: ;
                endcase
            end

            OP_STORE: begin
                case (funct3)
                    F3_WORD, F3_BYTE: begin
                        ctrl.memWrite = (funct3 == F3_WORD) ? MEM_WORD : MEM_BYTE;
                        ctrl.aluSrc   = 1'b1;
                        ctrl.immSrc   = IMM_S;
                    end
                    default: ;
                endcase
            end

            default: ;
        endcase
    end

    // a store never also updates a register
    always_comb begin
        assert (!(ctrl.regWrite && ctrl.memWrite != MEM_NONE))
            else $error("controlUnit: regWrite and memWrite both active");
    end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu import isaPkg::*; import ctrlPkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  aluOp_e          op,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];              // rv32 shifts use 5 bits

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SLL: result = a << shamt;
            ALU_XOR: result = a ^ b;
            ALU_SRL: result = a >> shamt;   // logical shift with zero fill
            ALU_AND: result = a & b;
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);       // branch compare via xor

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps

module regFile import isaPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we,
    input  logic [REG_IDX_W-1:0] rs1,
    input  logic [REG_IDX_W-1:0] rs2,
    input  logic [REG_IDX_W-1:0] rd,
    input  logic [XLEN-1:0]      wd,
    output logic [XLEN-1:0]      rd1,
    output logic [XLEN-1:0]      rd2,
    output logic [XLEN-1:0]      a0
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // x0 writes dropped
            regs[rd] <= wd;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];
    assign a0  = regs[10];              // x10 for observation

    // x0 stays zero through reset and write gating
    x0Rs1: assert property (@(posedge clk) disable iff (rst) (rs1 == '0) |-> (rd1 == '0));
    x0Rs2: assert property (@(posedge clk) disable iff (rst) (rs2 == '0) |-> (rd2 == '0));

endmodule

// File: hdl/signExtend.sv
`timescale 1ns/1ps

module signExtend import isaPkg::*; import ctrlPkg::*; (
    input  logic [XLEN-1:0] instr,
    input  immSrc_e         immSrc,
    output logic [XLEN-1:0] imm
);

    logic sign;

    assign sign = instr[31];            // all formats keep sign at 31

    always_comb begin
        case (immSrc)
            IMM_I: imm = {{20{sign}}, instr[31:20]};
            IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // branch offset with bit 0 implied
            IMM_B: imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
            // 21-bit jump offset
            IMM_J: imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
                          instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// File: hdl/dataMem.sv
`timescale 1ns/1ps

module dataMem import isaPkg::*; import ctrlPkg::*; #(
    parameter int DMEM_BYTES = 1024
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wdata,
    input  memMode_e        readMode,
    input  memMode_e        writeMode,
    output logic [XLEN-1:0] rdata
);

    localparam int AW = $clog2(DMEM_BYTES);

    logic [7:0]    mem [DMEM_BYTES];
    logic [AW-1:0] byteAddr;

    assign byteAddr = addr[AW-1:0];     // wraps past the top

    // ========================================
    // little-endian read
    // ========================================
    always_comb begin
        case (readMode)
            MEM_WORD: rdata = {mem[byteAddr + AW'(3)], mem[byteAddr + AW'(2)],
                               mem[byteAddr + AW'(1)], mem[byteAddr]};
            MEM_BYTE: rdata = {{24{mem[byteAddr][7]}}, mem[byteAddr]};  // lb
            default:  rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_BYTES; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (writeMode)
                MEM_WORD: begin
                    mem[byteAddr]          <= wdata[7:0];
                    mem[byteAddr + AW'(1)] <= wdata[15:8];
                    mem[byteAddr + AW'(2)] <= wdata[23:16];
                    mem[byteAddr + AW'(3)] <= wdata[31:24];
                end
                MEM_BYTE: mem[byteAddr] <= wdata[7:0];  // low byte only
                default: ;
            endcase
        end
    end

    wordAligned: assert property (@(posedge clk) disable iff (rst)
        (readMode == MEM_WORD || writeMode == MEM_WORD) |-> (addr[1:0] == 2'b00));

endmodule

// File: hdl/instrMem.sv
`timescale 1ns/1ps

module instrMem import isaPkg::*; #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          progWe,
    input  logic [$clog2(IMEM_WORDS)-1:0] progAddr,
    input  logic [XLEN-1:0]               progData,
    input  logic [XLEN-1:0]               pc,
    output logic [XLEN-1:0]               instr
);

    localparam int AW = $clog2(IMEM_WORDS);

    logic [XLEN-1:0] mem [IMEM_WORDS];

    // load port writes only while the core is held
    always_ff @(posedge clk) begin
        if (rst && progWe) begin
            mem[progAddr] <= progData;
        end
    end

    assign instr = mem[pc[AW+1:2]];     // word index = pc / 4

    loadInReset: assert property (@(posedge clk) progWe |-> rst)
        else $error("instrMem: program write with core running");

endmodule

// File: hdl/pcUnit.sv
`timescale 1ns/1ps

module pcUnit import isaPkg::*; import ctrlPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  pcSrc_e          pcSrc,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] regTarget,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] pcPlus4
);

    logic [XLEN-1:0] pcNext;

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (pcSrc)
            PC_REL:  pcNext = pc + imm;                         // branch, jal
            PC_REG:  pcNext = {regTarget[XLEN-1:1], 1'b0};      // jalr
            default: pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// File: hdl/riscvTop.sv
`timescale 1ns/1ps

module riscvTop import isaPkg::*; import ctrlPkg::*; #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_BYTES = 1024
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          progWe,
    input  logic [$clog2(IMEM_WORDS)-1:0] progAddr,
    input  logic [XLEN-1:0]               progData,
    output logic [XLEN-1:0]               pc,
    output logic [XLEN-1:0]               a0
);

    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResult;
    logic            aluZero;
    logic [XLEN-1:0] memData;
    logic [XLEN-1:0] result;
    ctrl_t           ctrl;

    // ========================================
    // fetch and decode
    // ========================================
    pcUnit u_pcUnit (
        .clk       (clk),
        .rst       (rst),
        .pcSrc     (ctrl.pcSrc),
        .imm       (imm),
        .regTarget (aluResult),
        .pc        (pc),
        .pcPlus4   (pcPlus4)
    );

    instrMem #(.IMEM_WORDS(IMEM_WORDS)) u_instrMem (
        .clk      (clk),
        .rst      (rst),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .instr    (instr)
    );

    controlUnit u_controlUnit (
        .op      (instr[6:0]),
        .funct3  (instr[14:12]),
        .funct7  (instr[30]),
        .aluZero (aluZero),
        .ctrl    (ctrl)
    );

    signExtend u_signExtend (
        .instr  (instr),
        .immSrc (ctrl.immSrc),
        .imm    (imm)
    );

    // ========================================
    // execute, memory, write back
    // ========================================
    regFile u_regFile (
        .clk (clk),
        .rst (rst),
        .we  (ctrl.regWrite),
        .rs1 (instr[19:15]),
        .rs2 (instr[24:20]),
        .rd  (instr[11:7]),
        .wd  (result),
        .rd1 (rs1Data),
        .rd2 (rs2Data),
        .a0  (a0)
    );

    assign aluB = ctrl.aluSrc ? imm : rs2Data;

    alu u_alu (
        .a      (rs1Data),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    dataMem #(.DMEM_BYTES(DMEM_BYTES)) u_dataMem (
        .clk       (clk),
        .rst       (rst),
        .addr      (aluResult),
        .wdata     (rs2Data),
        .readMode  (ctrl.memRead),
        .writeMode (ctrl.memWrite),
        .rdata     (memData)
    );

    assign result = (ctrl.resultSrc == RES_MEM) ? memData :
                    (ctrl.resultSrc == RES_PC4) ? pcPlus4 : aluResult;

endmodule

// File: bench/riscvTb.sv
`timescale 1ns/1ps

module riscvTb;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_BYTES = 1024;
    localparam int PA_W       = $clog2(IMEM_WORDS);
    localparam int TIMEOUT    = 1000;           // cycles per program run

    logic            clk;
    logic            rst;
    logic            progWe;
    logic [PA_W-1:0] progAddr;
    logic [31:0]     progData;
    logic [31:0]     pc;
    logic [31:0]     a0;

    logic [31:0] prog [$];                      // program under construction
    logic [31:0] lcgState;

    riscvTop #(.IMEM_WORDS(IMEM_WORDS), .DMEM_BYTES(DMEM_BYTES)) u_riscvTop (
        .clk      (clk),
        .rst      (rst),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .a0       (a0)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // instruction encoders
    // ========================================
    function automatic logic [31:0] encR(int f7, int f3, int rd, int rs1, int rs2);
        return ((f7 & 'h7f) << 25) | ((rs2 & 31) << 20) | ((rs1 & 31) << 15)
             | ((f3 & 7) << 12) | ((rd & 31) << 7) | 'h33;
    endfunction

    function automatic logic [31:0] encI(int imm, int rs1, int f3, int rd, int op);
        return ((imm & 'hfff) << 20) | ((rs1 & 31) << 15) | ((f3 & 7) << 12)
             | ((rd & 31) << 7) | (op & 'h7f);
    endfunction

    function automatic logic [31:0] encS(int imm, int f3, int rs1, int rs2);
        return (((imm >> 5) & 'h7f) << 25) | ((rs2 & 31) << 20) | ((rs1 & 31) << 15)
             | ((f3 & 7) << 12) | ((imm & 'h1f) << 7) | 'h23;
    endfunction

    function automatic logic [31:0] encB(int imm, int f3, int rs1, int rs2);
        return (((imm >> 12) & 1) << 31) | (((imm >> 5) & 'h3f) << 25)
             | ((rs2 & 31) << 20) | ((rs1 & 31) << 15) | ((f3 & 7) << 12)
             | (((imm >> 1) & 'hf) << 8) | (((imm >> 11) & 1) << 7) | 'h63;
    endfunction

    function automatic logic [31:0] encJ(int imm, int rd);
        return (((imm >> 20) & 1) << 31) | (((imm >> 1) & 'h3ff) << 21)
             | (((imm >> 11) & 1) << 20) | (((imm >> 12) & 'hff) << 12)
             | ((rd & 31) << 7) | 'h6f;
    endfunction

    function automatic logic [31:0] encAddi(int rd, int rs1, int imm);
        return encI(imm, rs1, 0, rd, 'h13);
    endfunction

    // ========================================
    // reference model and stimulus helpers
    // ========================================
    function automatic logic [31:0] aluModel(int f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            0:       return a + b;
            1:       return a << b[4:0];                // shift amount from low 5 bits
            4:       return a ^ b;
            5:       return a >> b[4:0];
            default: return a & b;
        endcase
    endfunction

    function automatic int sext12(int v);
        int low;
        low = v & 'hfff;
        return (low >= 2048) ? low - 4096 : low;
    endfunction

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "%s: value mismatch", name);
        end
    endtask

    task automatic startProgram();
        prog.delete();
        prog.push_back(encAddi(30, 0, 10));         // shift amounts for pushConst
        prog.push_back(encAddi(31, 0, 11));
    endtask

    // builds a 32-bit value in rd from 11, 11 and 10 bit chunks
    task automatic pushConst(input int rd, input logic [31:0] val);
        prog.push_back(encAddi(rd, 0, int'(val[31:21])));
        prog.push_back(encR(0, 1, rd, rd, 31));
        prog.push_back(encAddi(rd, rd, int'(val[20:10])));
        prog.push_back(encR(0, 1, rd, rd, 30));
        prog.push_back(encAddi(rd, rd, int'(val[9:0])));
    endtask

    task automatic loadProgram();
        @(posedge clk);
        rst    <= 1'b1;
        progWe <= 1'b0;
        repeat (5) @(posedge clk);                  // reset held 5 cycles
        foreach (prog[i]) begin
            progWe   <= 1'b1;
            progAddr <= PA_W'(i);
            progData <= prog[i];
            @(posedge clk);
        end
        progWe <= 1'b0;
    endtask

    task automatic runProgram(input string name);
        logic [31:0] haltAddr;
        int          cycles;
        prog.push_back(encJ(0, 0));                 // jal x0, 0 spins here
        haltAddr = 32'((prog.size() - 1) * 4);
        loadProgram();
        rst    <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (pc !== haltAddr && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (pc !== haltAddr) begin
            $display("%s: pc did not reach the halt address %h, pc is %h",
                     name, haltAddr, pc);
            $display("ERRORS FOUND");
            $fatal(1, "%s: timeout", name);
        end
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic testAluOps();
        int          funcs [5] = '{0, 1, 4, 5, 7};
        logic [31:0] a;
        logic [31:0] b;
        string       name;
        for (int i = 0; i < 5; i++) begin
            for (int n = 0; n < 2; n++) begin
                a    = lcgNext();
                b    = lcgNext();
                name = $sformatf("alu funct3=%0d run %0d", funcs[i], n);
                startProgram();
                pushConst(5, a);
                pushConst(6, b);
                prog.push_back(encR(0, funcs[i], 7, 5, 6));
                prog.push_back(encR(0, 0, 10, 7, 0));   // move to a0
                runProgram(name);
                checkValue(name, aluModel(funcs[i], a, b), a0);
            end
        end
    endtask

    task automatic testAddi();
        int immA [3] = '{100, 2047, -1};
        int immB [3] = '{-300, -2048, -1};
        int ia;
        int ib;
        for (int i = 0; i < 5; i++) begin
            if (i < 3) begin
                ia = immA[i];
                ib = immB[i];
            end else begin
                ia = int'(lcgNext() & 32'hfff);     // random 12-bit fields
                ib = int'(lcgNext() & 32'hfff);
            end
            startProgram();
            prog.push_back(encAddi(5, 0, ia));
            prog.push_back(encAddi(10, 5, ib));
            runProgram("addi sign extension");
            checkValue($sformatf("addi %0d %0d", ia, ib), sext12(ia) + sext12(ib), a0);
        end
    endtask

    task automatic testLoadStore();
        logic [31:0] w;
        w = lcgNext();
        startProgram();
        pushConst(5, w);
        prog.push_back(encAddi(6, 0, 64));          // base address
        prog.push_back(encS(12, 2, 6, 5));          // sw x5, 12(x6)
        prog.push_back(encI(12, 6, 2, 10, 'h03));   // lw a0, 12(x6)
        runProgram("sw lw");
        checkValue("sw lw", w, a0);

        startProgram();
        prog.push_back(encAddi(6, 0, 64));
        prog.push_back(encAddi(5, 0, 'h80));
        prog.push_back(encS(5, 0, 6, 5));           // sb x5, 5(x6)
        prog.push_back(encI(5, 6, 0, 10, 'h03));    // lb a0, 5(x6)
        runProgram("sb lb");
        checkValue("sb lb", 32'hffffff80, a0);

        w = lcgNext();
        startProgram();
        pushConst(5, w);
        prog.push_back(encAddi(6, 0, 64));
        prog.push_back(encS(8, 2, 6, 5));
        prog.push_back(encAddi(7, 0, 'hab));
        prog.push_back(encS(10, 0, 6, 7));          // byte 2 of the word
        prog.push_back(encI(8, 6, 2, 10, 'h03));
        runProgram("sb into word");
        checkValue("sb into word", {w[31:24], 8'hab, w[15:0]}, a0);
    endtask

    task automatic testBranches();
        startProgram();
        prog.push_back(encAddi(5, 0, 7));
        prog.push_back(encAddi(6, 0, 7));
        prog.push_back(encAddi(7, 0, 3));
        prog.push_back(encB(8, 0, 5, 6));           // beq taken
        prog.push_back(encAddi(10, 10, 1));
        prog.push_back(encB(8, 0, 5, 7));           // beq falls through
        prog.push_back(encAddi(10, 10, 2));
        prog.push_back(encB(8, 1, 5, 7));           // bne taken
        prog.push_back(encAddi(10, 10, 4));
        prog.push_back(encB(8, 1, 5, 6));           // bne falls through
        prog.push_back(encAddi(10, 10, 8));
        prog.push_back(encAddi(8, 0, 3));
        prog.push_back(encAddi(10, 10, 16));        // loop body runs three times
        prog.push_back(encAddi(8, 8, -1));
        prog.push_back(encB(-8, 1, 8, 0));          // backward bne
        runProgram("branches");
        checkValue("branches", 32'd2 + 32'd8 + 32'd48, a0);
    endtask

    task automatic testJumps();
        logic [31:0] linkAddr;
        logic [31:0] target;
        startProgram();
        prog.push_back(encAddi(5, 0, 1));
        linkAddr = 32'((prog.size() + 1) * 4);
        prog.push_back(encJ(8, 10));                // jal a0, +8
        prog.push_back(encAddi(5, 5, 100));         // skipped
        prog.push_back(encR(0, 0, 10, 10, 5));
        runProgram("jal");
        checkValue("jal", linkAddr + 32'd1, a0);

        startProgram();
        linkAddr = 32'((prog.size() + 2) * 4);      // jalr sits after the addi
        target   = linkAddr + 32'd12;
        prog.push_back(encAddi(6, 0, int'(target) - 3));    // rs1 + 4 is odd
        prog.push_back(encI(4, 6, 0, 10, 'h67));
        prog.push_back(encAddi(10, 0, 99));
        prog.push_back(encAddi(10, 0, 99));
        prog.push_back(encAddi(10, 0, 99));
        prog.push_back(encAddi(10, 10, 1000));      // jump target
        runProgram("jalr");
        checkValue("jalr", linkAddr + 32'd1000, a0);
    endtask

    task automatic testUnsupported();
        startProgram();
        prog.push_back(encAddi(10, 0, 55));
        prog.push_back(encI(123, 10, 0, 10, 'h0b)); // custom opcode
        prog.push_back(encR(32, 0, 10, 10, 10));    // sub is not in the subset
        prog.push_back(encI(0, 0, 4, 10, 'h03));    // lbu
        prog.push_back(encAddi(0, 0, 77));
        prog.push_back(encR(0, 0, 10, 10, 0));      // add a0, a0, x0
        runProgram("unsupported and x0");
        checkValue("unsupported and x0", 32'd55, a0);
    endtask

    initial begin
        rst      = 1'b1;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        lcgState = 32'hed32;

        testAluOps();
        testAddi();
        testLoadStore();
        testBranches();
        testJumps();
        testUnsupported();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: verilog.f
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/controlUnit.sv
hdl/alu.sv
hdl/regFile.sv
hdl/signExtend.sv
hdl/dataMem.sv
hdl/instrMem.sv
hdl/pcUnit.sv
hdl/riscvTop.sv
bench/riscvTb.sv

// File: Makefile
# Verilator build and run of the single-cycle RV32I subset core

TOP       ?= riscvTb
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(SIM_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: TOP SIM_DIR LOG VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f verilog.f
	-$(SIM_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "NO ERRORS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(SIM_DIR) $(LOG)
